// File: compile.f
hw/sdram_geom_pkg.sv
hw/sdram_cmd_pkg.sv
hw/req_slot.sv
hw/refresh_timer.sv
hw/bank_tracker.sv
hw/cmd_sequencer.sv
hw/read_capture.sv
hw/sdram_ctrl_top.sv
tb/sdram_ctrl_checker.sv
tb/tb_sdram_ctrl.sv

// File: tb/tb_sdram_ctrl.sv
`timescale 1ns/10ps

module tb_sdram_ctrl;
    import sdram_geom_pkg::*;
    import sdram_cmd_pkg::*;

    localparam int CL = CAS_LAT_DEF;

    logic              clk = 1'b0;
    logic              rst;
    logic [ADDR_W-1:0] user_addr;
    logic              rw;
    logic [DATA_W-1:0] data_in;
    logic              in_valid;
    logic              busy;
    logic [DATA_W-1:0] data_out;
    logic              out_valid;
    logic [DATA_W-1:0] sdram_dqi;
    logic              sdram_cke;
    logic              sdram_cs;
    logic              sdram_ras;
    logic              sdram_cas;
    logic              sdram_we;
    logic              sdram_dqm;
    logic [BANK_W-1:0] sdram_ba;
    logic [ROW_W-1:0]  sdram_a;
    logic [DATA_W-1:0] sdram_dqo;
    logic              sdram_dq_oe;

    logic [31:0]       lfsr = 32'h5c977583;
    logic [DATA_W-1:0] exp_mem [logic [ADDR_W-3:0]];
    logic [DATA_W-1:0] dram [logic [20:0]];
    logic [ROW_W-1:0]  dram_row [NUM_BANKS];
    logic [DATA_W-1:0] rd_pipe [CL-1];
    int                errors = 0;
    int                checks = 0;
    int unsigned       cyc = 0;

    sdram_ctrl_top sdram_ctrl_top_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // behavioral SDRAM, decodes the pins registered in the previous cycle
    always @(posedge clk) begin
        logic [3:0] cmd;
        cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};
        for (int i = CL - 2; i > 0; i--) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_pipe[0] <= '0;
        sdram_dqi  <= rd_pipe[CL-2];
        if (!rst && cmd == CMD_ACTIVE) begin
            dram_row[sdram_ba] = sdram_a;
        end
        if (!rst && cmd == CMD_WRITE && sdram_dq_oe) begin
            dram[{sdram_ba, dram_row[sdram_ba], sdram_a[5:0]}] = sdram_dqo;
        end
        if (!rst && cmd == CMD_READ) begin
            if (dram.exists({sdram_ba, dram_row[sdram_ba], sdram_a[5:0]})) begin
                rd_pipe[0] <= dram[{sdram_ba, dram_row[sdram_ba], sdram_a[5:0]}];
            end
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            // right-shifting Galois form, taps 32 22 2 1
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (1) begin
            @(posedge clk);
            if (!busy) begin
                break;
            end
            n++;
            if (n > 200) begin
                $display("busy stayed high too long");
                errors++;
                break;
            end
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] d);
        wait_ready();
        in_valid  <= 1'b1;
        rw        <= 1'b1;
        user_addr <= addr;
        data_in   <= d;
        @(posedge clk);
        in_valid  <= 1'b0;
        exp_mem[addr[ADDR_W-1:2]] = d;
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] exp;
        int n;
        exp = exp_mem.exists(addr[ADDR_W-1:2]) ? exp_mem[addr[ADDR_W-1:2]] : '0;
        wait_ready();
        in_valid  <= 1'b1;
        rw        <= 1'b0;
        user_addr <= addr;
        @(posedge clk);
        in_valid  <= 1'b0;
        n = 0;
        while (!out_valid) begin
            @(posedge clk);
            n++;
            if (n > 100) begin
                $display("no out_valid after a read");
                errors++;
                return;
            end
        end
        checks++;
        if (data_out !== exp) begin
            $display("Fail data_out: expected %h, got %h", exp, data_out);
            errors++;
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] rnd_addr [8];
        int e0;
        int unsigned stop;
        rst = 1'b1;
        in_valid = 1'b0;
        rw = 1'b0;
        user_addr = '0;
        data_in = '0;
        sdram_dqi = '0;
        for (int i = 0; i < CL - 1; i++) begin
            rd_pipe[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;
        wait_ready();
        $display("startup: errors %0d", errors - e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            rnd_addr[i] = ADDR_W'(rand_bits(ADDR_W));
            write_word(rnd_addr[i], rand_bits(DATA_W));
        end
        for (int i = 0; i < 8; i++) begin
            read_check(rnd_addr[i]);
            // byte offset bits alias the same word
            read_check(rnd_addr[i] ^ 23'h3);
        end
        $display("write then read: errors %0d", errors - e0);

        e0 = errors;
        a = ADDR_W'(rand_bits(ADDR_W));
        write_word(a, rand_bits(DATA_W));
        write_word(a ^ 23'h4, rand_bits(DATA_W));
        write_word(a ^ 23'h400, rand_bits(DATA_W));
        write_word(a ^ 23'h100, rand_bits(DATA_W));
        read_check(a ^ 23'h4);
        read_check(a);
        read_check(a ^ 23'h100);
        read_check(a ^ 23'h400);
        read_check(a ^ 23'h500);
        $display("row policy: errors %0d", errors - e0);

        e0 = errors;
        a = ADDR_W'(rand_bits(ADDR_W));
        write_word(a, 32'h0bad_f00d);
        // second valid lands while busy and must be dropped
        in_valid  <= 1'b1;
        rw        <= 1'b1;
        user_addr <= a;
        data_in   <= 32'hdead_beef;
        @(posedge clk);
        in_valid  <= 1'b0;
        read_check(a);
        $display("handshake: errors %0d", errors - e0);

        e0 = errors;
        stop = cyc + 2 * REFRESH_INTERVAL_DEF + 200;
        while (cyc < stop) begin
            a = ADDR_W'(rand_bits(ADDR_W));
            write_word(a, rand_bits(DATA_W));
            read_check(a);
        end
        $display("refresh: errors %0d", errors - e0);

        repeat (10) @(posedge clk);
        errors += sdram_ctrl_top_inst.checker_inst.fail_count;
        $display("data checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb/sdram_ctrl_checker.sv
`timescale 1ns/10ps

module sdram_ctrl_checker #(
    parameter int CAS_LATENCY      = sdram_geom_pkg::CAS_LAT_DEF,
    parameter int REFRESH_INTERVAL = sdram_geom_pkg::REFRESH_INTERVAL_DEF
) (
    input logic                              clk,
    input logic                              rst,
    input logic                              busy,
    input logic                              in_valid,
    input logic                              rw,
    input logic                              out_valid,
    input logic                              take,
    input logic                              pending,
    input logic [sdram_geom_pkg::ADDR_W-1:0] req_addr,
    input logic                              sdram_cke,
    input logic                              sdram_cs,
    input logic                              sdram_ras,
    input logic                              sdram_cas,
    input logic                              sdram_we,
    input logic                              sdram_dqm,
    input logic [sdram_geom_pkg::BANK_W-1:0] sdram_ba,
    input logic [sdram_geom_pkg::ROW_W-1:0]  sdram_a,
    input logic                              sdram_dq_oe
);
    import sdram_geom_pkg::*;
    import sdram_cmd_pkg::*;

    logic [3:0]           cmd;
    logic [NUM_BANKS-1:0] act_q;
    logic [ROW_W-1:0]     act_row_q [NUM_BANKS];
    logic                 last_pre_all_q;
    logic [ADDR_W-1:0]    taken_addr_q;
    int unsigned          wr_acc_q;
    int unsigned          wr_cmd_q;
    int unsigned          ref_gap_q;
    int                   fail_count = 0;

    assign cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};

    // shadow of the bank state as seen on the pins
    always_ff @(posedge clk) begin
        if (rst) begin
            act_q          <= '0;
            last_pre_all_q <= 1'b0;
            wr_acc_q       <= 0;
            wr_cmd_q       <= 0;
            ref_gap_q      <= 0;
        end else begin
            if (cmd == CMD_PRECHARGE) begin
                if (sdram_a[10]) begin
                    act_q <= '0;
                end else begin
                    act_q[sdram_ba] <= 1'b0;
                end
            end
            if (cmd == CMD_ACTIVE) begin
                act_q[sdram_ba]     <= 1'b1;
                act_row_q[sdram_ba] <= sdram_a;
            end
            if (cmd != CMD_NOP) begin
                last_pre_all_q <= (cmd == CMD_PRECHARGE) && sdram_a[10];
            end
            ref_gap_q <= (cmd == CMD_REFRESH) ? 0 : ref_gap_q + 1;
            if (in_valid && !busy && rw) begin
                wr_acc_q <= wr_acc_q + 1;
            end
            if (cmd == CMD_WRITE) begin
                wr_cmd_q <= wr_cmd_q + 1;
            end
            if (take && pending) begin
                taken_addr_q <= req_addr;
            end
        end
    end

    a_startup: assert property (@(posedge clk)
        $fell(rst) |-> (!sdram_cke && !sdram_dq_oe && !out_valid)
                       ##1 (cmd == CMD_LOAD_MODE && sdram_cke) ##[1:10] !busy)
        else begin
            fail_count++;
            $error("start-up sequence wrong");
        end

    // row in bits 22:10, bank in 9:8, column in 7:2
    a_rw_open: assert property (@(posedge clk) disable iff (rst)
        (cmd == CMD_READ || cmd == CMD_WRITE) |->
            act_q[sdram_ba] && act_row_q[sdram_ba] == taken_addr_q[22:10] &&
            sdram_ba == taken_addr_q[9:8] &&
            sdram_a[5:0] == taken_addr_q[7:2])
        else begin
            fail_count++;
            $error("read or write without matching open row");
        end

    a_act_closed: assert property (@(posedge clk) disable iff (rst)
        (cmd == CMD_ACTIVE) |-> !act_q[sdram_ba])
        else begin
            fail_count++;
            $error("activate on a bank that was not precharged");
        end

    a_ref_pre: assert property (@(posedge clk) disable iff (rst)
        (cmd == CMD_REFRESH) |-> (act_q == '0) && last_pre_all_q)
        else begin
            fail_count++;
            $error("refresh without precharge-all");
        end

    a_ref_gap: assert property (@(posedge clk) disable iff (rst)
        ref_gap_q <= REFRESH_INTERVAL + 40)
        else begin
            fail_count++;
            $error("refresh interval exceeded");
        end

    a_oe_write: assert property (@(posedge clk) disable iff (rst)
        sdram_dq_oe == (cmd == CMD_WRITE))
        else begin
            fail_count++;
            $error("dq_oe not aligned with write command");
        end

    a_dqm_low: assert property (@(posedge clk) disable iff (rst)
        !sdram_dqm)
        else begin
            fail_count++;
            $error("data mask raised");
        end

    a_wr_count: assert property (@(posedge clk) disable iff (rst)
        (cmd == CMD_WRITE) |-> wr_cmd_q < wr_acc_q)
        else begin
            fail_count++;
            $error("more write commands than accepted writes");
        end

    a_out_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(cmd == CMD_READ, CAS_LATENCY + 1))
        else begin
            fail_count++;
            $error("out_valid without read command");
        end

endmodule

bind sdram_ctrl_top sdram_ctrl_checker #(
    .CAS_LATENCY      (CAS_LATENCY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
) checker_inst (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .in_valid    (in_valid),
    .rw          (rw),
    .out_valid   (out_valid),
    .take        (take),
    .pending     (pending),
    .req_addr    (req.addr),
    .sdram_cke   (sdram_cke),
    .sdram_cs    (sdram_cs),
    .sdram_ras   (sdram_ras),
    .sdram_cas   (sdram_cas),
    .sdram_we    (sdram_we),
    .sdram_dqm   (sdram_dqm),
    .sdram_ba    (sdram_ba),
    .sdram_a     (sdram_a),
    .sdram_dq_oe (sdram_dq_oe)
);

// File: hw/sdram_ctrl_top.sv
`timescale 1ns/10ps

module sdram_ctrl_top #(
    parameter int T_ACT            = sdram_geom_pkg::T_ACT_DEF,
    parameter int T_PRE            = sdram_geom_pkg::T_PRE_DEF,
    parameter int T_REF            = sdram_geom_pkg::T_REF_DEF,
    parameter int CAS_LATENCY      = sdram_geom_pkg::CAS_LAT_DEF,
    parameter int REFRESH_INTERVAL = sdram_geom_pkg::REFRESH_INTERVAL_DEF
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [sdram_geom_pkg::ADDR_W-1:0] user_addr,
    input  logic                              rw,
    input  logic [sdram_geom_pkg::DATA_W-1:0] data_in,
    input  logic                              in_valid,
    output logic                              busy,
    output logic [sdram_geom_pkg::DATA_W-1:0] data_out,
    output logic                              out_valid,
    input  logic [sdram_geom_pkg::DATA_W-1:0] sdram_dqi,
    output logic                              sdram_cke,
    output logic                              sdram_cs,
    output logic                              sdram_ras,
    output logic                              sdram_cas,
    output logic                              sdram_we,
    output logic                              sdram_dqm,
    output logic [sdram_geom_pkg::BANK_W-1:0] sdram_ba,
    output logic [sdram_geom_pkg::ROW_W-1:0]  sdram_a,
    output logic [sdram_geom_pkg::DATA_W-1:0] sdram_dqo,
    output logic                              sdram_dq_oe
);
    import sdram_geom_pkg::*;
    import sdram_cmd_pkg::*;

    user_req_t          req;
    logic               pending;
    logic               take;
    logic               refresh_pending;
    logic               refresh_take;
    logic               row_hit;
    logic               bank_open;
    logic               open_en;
    logic [BANK_W-1:0]  open_bank;
    logic [ROW_W-1:0]   open_row;
    logic               close_en;
    logic [BANK_W-1:0]  close_bank;
    logic               close_all;
    logic               read_issue;
    sdram_pins_t        pins;

    req_slot req_slot_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .rw        (rw),
        .user_addr (user_addr),
        .data_in   (data_in),
        .take      (take),
        .busy      (busy),
        .req       (req),
        .pending   (pending)
    );

    refresh_timer #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) refresh_timer_inst (
        .clk             (clk),
        .rst             (rst),
        .refresh_take    (refresh_take),
        .refresh_pending (refresh_pending)
    );

    // classify the request still sitting in the slot
    bank_tracker #(
        .NUM_BANKS (NUM_BANKS)
    ) bank_tracker_inst (
        .clk        (clk),
        .rst        (rst),
        .req_bank   (addr_bank(req.addr)),
        .req_row    (addr_row(req.addr)),
        .open_en    (open_en),
        .open_bank  (open_bank),
        .open_row   (open_row),
        .close_en   (close_en),
        .close_bank (close_bank),
        .close_all  (close_all),
        .row_hit    (row_hit),
        .bank_open  (bank_open)
    );

    cmd_sequencer #(
        .T_ACT       (T_ACT),
        .T_PRE       (T_PRE),
        .T_REF       (T_REF),
        .CAS_LATENCY (CAS_LATENCY)
    ) cmd_sequencer_inst (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .pending         (pending),
        .refresh_pending (refresh_pending),
        .row_hit         (row_hit),
        .bank_open       (bank_open),
        .take            (take),
        .refresh_take    (refresh_take),
        .open_en         (open_en),
        .open_bank       (open_bank),
        .open_row        (open_row),
        .close_en        (close_en),
        .close_bank      (close_bank),
        .close_all       (close_all),
        .read_issue      (read_issue),
        .pins            (pins)
    );

    read_capture #(
        .CAS_LATENCY (CAS_LATENCY)
    ) read_capture_inst (
        .clk        (clk),
        .rst        (rst),
        .read_issue (read_issue),
        .sdram_dqi  (sdram_dqi),
        .data_out   (data_out),
        .out_valid  (out_valid)
    );

    // pins from the strobe view of the command word
    assign sdram_cke   = pins.cke;
    assign sdram_cs    = pins.cmd.bits.cs;
    assign sdram_ras   = pins.cmd.bits.ras;
    assign sdram_cas   = pins.cmd.bits.cas;
    assign sdram_we    = pins.cmd.bits.we;
    assign sdram_ba    = pins.ba;
    assign sdram_a     = pins.a;
    assign sdram_dqo   = pins.dq;
    assign sdram_dq_oe = pins.dq_oe;
    // all byte lanes always enabled
    assign sdram_dqm   = 1'b0;

endmodule

// File: hw/read_capture.sv
`timescale 1ns/10ps

module read_capture #(
    parameter int CAS_LATENCY = sdram_geom_pkg::CAS_LAT_DEF
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              read_issue,
    input  logic [sdram_geom_pkg::DATA_W-1:0] sdram_dqi,
    output logic [sdram_geom_pkg::DATA_W-1:0] data_out,
    output logic                              out_valid
);
    logic [CAS_LATENCY-1:0] issue_sr;
    logic                   sample;

    // top tap lines up with the data cas latency cycles after the read
    assign sample = issue_sr[CAS_LATENCY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_sr  <= '0;
            out_valid <= 1'b0;
        end else begin
            issue_sr  <= (issue_sr << 1) | CAS_LATENCY'(read_issue);
            out_valid <= sample;
        end
    end

    // held until the next read returns
    always_ff @(posedge clk) begin
        if (sample) begin
            data_out <= sdram_dqi;
        end
    end

endmodule

// File: hw/cmd_sequencer.sv
`timescale 1ns/10ps

module cmd_sequencer #(
    parameter int T_ACT       = sdram_geom_pkg::T_ACT_DEF,
    parameter int T_PRE       = sdram_geom_pkg::T_PRE_DEF,
    parameter int T_REF       = sdram_geom_pkg::T_REF_DEF,
    parameter int CAS_LATENCY = sdram_geom_pkg::CAS_LAT_DEF
) (
    input  logic                              clk,
    input  logic                              rst,
    input  sdram_geom_pkg::user_req_t         req,
    input  logic                              pending,
    input  logic                              refresh_pending,
    input  logic                              row_hit,
    input  logic                              bank_open,
    output logic                              take,
    output logic                              refresh_take,
    output logic                              open_en,
    output logic [sdram_geom_pkg::BANK_W-1:0] open_bank,
    output logic [sdram_geom_pkg::ROW_W-1:0]  open_row,
    output logic                              close_en,
    output logic [sdram_geom_pkg::BANK_W-1:0] close_bank,
    output logic                              close_all,
    output logic                              read_issue,
    output sdram_cmd_pkg::sdram_pins_t        pins
);
    import sdram_geom_pkg::*;
    import sdram_cmd_pkg::*;

    localparam int DLY_MAX = (T_ACT > T_PRE) ? ((T_ACT > T_REF) ? T_ACT : T_REF)
                                             : ((T_PRE > T_REF) ? T_PRE : T_REF);
    localparam int DLY_W   = $clog2(DLY_MAX + 2);

    // burst length 1, sequential, cas latency in a[6:4]
    localparam logic [ROW_W-1:0] MODE_WORD = {3'b000, 1'b0, 2'b00, 3'(CAS_LATENCY),
                                              1'b0, 3'b000};

    seq_state_t       state_q;
    seq_state_t       state_d;
    seq_state_t       ret_q;
    seq_state_t       ret_d;
    logic [DLY_W-1:0] dly_q;
    logic [DLY_W-1:0] dly_d;
    logic             pre_all_q;
    logic             pre_all_d;
    logic             init_take_q;
    logic             accept_req;
    user_req_t        cur_q;
    sdram_pins_t      pins_d;

    // refresh wins over a waiting request
    assign refresh_take = (state_q == ST_IDLE) && refresh_pending;
    assign accept_req   = (state_q == ST_IDLE) && !refresh_pending && pending;
    // init_take opens the request slot after the mode load
    assign take         = accept_req | init_take_q;

    assign open_bank  = addr_bank(cur_q.addr);
    assign open_row   = addr_row(cur_q.addr);
    assign close_bank = addr_bank(cur_q.addr);
    assign close_all  = pre_all_q;

    always_comb begin
        state_d      = state_q;
        ret_d        = ret_q;
        dly_d        = dly_q;
        pre_all_d    = pre_all_q;
        open_en      = 1'b0;
        close_en     = 1'b0;
        pins_d.cke   = 1'b1;
        pins_d.cmd.code = CMD_NOP;
        pins_d.ba    = '0;
        pins_d.a     = '0;
        pins_d.dq    = cur_q.wdata;
        pins_d.dq_oe = 1'b0;

        case (state_q)
            ST_INIT: begin
                pins_d.cmd.code = CMD_LOAD_MODE;
                pins_d.a        = MODE_WORD;
                state_d         = ST_IDLE;
            end
            ST_IDLE: begin
                if (refresh_take) begin
                    pre_all_d = 1'b1;
                    ret_d     = ST_REFRESH;
                    state_d   = ST_PRECHARGE;
                end else if (accept_req) begin
                    pre_all_d = 1'b0;
                    if (row_hit) begin
                        // row already open, issue straight from the slot
                        pins_d.cmd.code = req.write ? CMD_WRITE : CMD_READ;
                        pins_d.ba       = addr_bank(req.addr);
                        pins_d.a        = ROW_W'(addr_col(req.addr));
                        pins_d.dq       = req.wdata;
                        pins_d.dq_oe    = req.write;
                    end else if (bank_open) begin
                        ret_d   = ST_ACTIVATE;
                        state_d = ST_PRECHARGE;
                    end else begin
                        state_d = ST_ACTIVATE;
                    end
                end
            end
            ST_PRECHARGE: begin
                pins_d.cmd.code = CMD_PRECHARGE;
                pins_d.ba       = close_bank;
                pins_d.a[10]    = pre_all_q;
                close_en        = 1'b1;
                dly_d           = DLY_W'(T_PRE);
                state_d         = ST_WAIT;
            end
            ST_REFRESH: begin
                pins_d.cmd.code = CMD_REFRESH;
                dly_d           = DLY_W'(T_REF);
                ret_d           = ST_IDLE;
                state_d         = ST_WAIT;
            end
            ST_ACTIVATE: begin
                pins_d.cmd.code = CMD_ACTIVE;
                pins_d.ba       = open_bank;
                pins_d.a        = open_row;
                open_en         = 1'b1;
                dly_d           = DLY_W'(T_ACT);
                ret_d           = cur_q.write ? ST_WRITE : ST_READ;
                state_d         = ST_WAIT;
            end
            ST_READ: begin
                pins_d.cmd.code = CMD_READ;
                pins_d.ba       = addr_bank(cur_q.addr);
                pins_d.a        = ROW_W'(addr_col(cur_q.addr));
                state_d         = ST_IDLE;
            end
            ST_WRITE: begin
                pins_d.cmd.code = CMD_WRITE;
                pins_d.ba       = addr_bank(cur_q.addr);
                pins_d.a        = ROW_W'(addr_col(cur_q.addr));
                pins_d.dq_oe    = 1'b1;
                state_d         = ST_IDLE;
            end
            ST_WAIT: begin
                // delay of n gives n+1 nop cycles
                if (dly_q == '0) begin
                    state_d = ret_q;
                end else begin
                    dly_d = dly_q - 1'b1;
                end
            end
            default: state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= ST_INIT;
            ret_q           <= ST_IDLE;
            dly_q           <= '0;
            pre_all_q       <= 1'b0;
            init_take_q     <= 1'b0;
            read_issue      <= 1'b0;
            pins.cke        <= 1'b0;
            pins.cmd.code   <= CMD_NOP;
            pins.dq_oe      <= 1'b0;
        end else begin
            state_q         <= state_d;
            ret_q           <= ret_d;
            dly_q           <= dly_d;
            pre_all_q       <= pre_all_d;
            init_take_q     <= (state_q == ST_INIT);
            read_issue      <= (pins_d.cmd.code == CMD_READ);
            pins.cke        <= pins_d.cke;
            pins.cmd        <= pins_d.cmd;
            pins.dq_oe      <= pins_d.dq_oe;
        end
    end

    always_ff @(posedge clk) begin
        pins.ba <= pins_d.ba;
        pins.a  <= pins_d.a;
        pins.dq <= pins_d.dq;
        if (accept_req) begin
            cur_q <= req;
        end
    end

endmodule

// File: hw/bank_tracker.sv
`timescale 1ns/10ps

module bank_tracker #(
    parameter int NUM_BANKS = sdram_geom_pkg::NUM_BANKS
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [sdram_geom_pkg::BANK_W-1:0] req_bank,
    input  logic [sdram_geom_pkg::ROW_W-1:0]  req_row,
    input  logic                              open_en,
    input  logic [sdram_geom_pkg::BANK_W-1:0] open_bank,
    input  logic [sdram_geom_pkg::ROW_W-1:0]  open_row,
    input  logic                              close_en,
    input  logic [sdram_geom_pkg::BANK_W-1:0] close_bank,
    input  logic                              close_all,
    output logic                              row_hit,
    output logic                              bank_open
);
    import sdram_geom_pkg::*;

    logic [NUM_BANKS-1:0] open_q;
    logic [ROW_W-1:0]     row_q [NUM_BANKS];

    assign bank_open = open_q[req_bank];
    assign row_hit   = bank_open && (row_q[req_bank] == req_row);

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else begin
            if (close_en) begin
                if (close_all) begin
                    open_q <= '0;
                end else begin
                    open_q[close_bank] <= 1'b0;
                end
            end
            if (open_en) begin
                open_q[open_bank] <= 1'b1;
            end
        end
    end

    // row only meaningful while its open flag is set
    always_ff @(posedge clk) begin
        if (open_en) begin
            row_q[open_bank] <= open_row;
        end
    end

endmodule

// File: hw/refresh_timer.sv
`timescale 1ns/10ps

module refresh_timer #(
    parameter int REFRESH_INTERVAL = sdram_geom_pkg::REFRESH_INTERVAL_DEF
) (
    input  logic clk,
    input  logic rst,
    input  logic refresh_take,
    output logic refresh_pending
);
    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             expire;

    assign expire = (cnt_q == CNT_W'(REFRESH_INTERVAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q           <= '0;
            refresh_pending <= 1'b0;
        end else begin
            // free running, restarts at every expiry
            if (expire) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            // a new expiry beats a take in the same cycle
            if (expire) begin
                refresh_pending <= 1'b1;
            end else if (refresh_take) begin
                refresh_pending <= 1'b0;
            end
        end
    end

endmodule

// File: hw/req_slot.sv
`timescale 1ns/10ps

module req_slot (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic                              rw,
    input  logic [sdram_geom_pkg::ADDR_W-1:0] user_addr,
    input  logic [sdram_geom_pkg::DATA_W-1:0] data_in,
    input  logic                              take,
    output logic                              busy,
    output sdram_geom_pkg::user_req_t         req,
    output logic                              pending
);
    logic ready_q;
    logic accept;

    // slot comes up closed, the first take after mode load opens it
    assign busy   = ~ready_q;
    assign accept = in_valid & ready_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            pending <= 1'b0;
        end else if (accept) begin
            ready_q <= 1'b0;
            pending <= 1'b1;
        end else if (take) begin
            ready_q <= 1'b1;
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.write <= rw;
            req.addr  <= user_addr;
            req.wdata <= data_in;
        end
    end

endmodule

// File: hw/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

    // {cs, ras, cas, we} as seen on the pins
    typedef enum logic [3:0] {
        CMD_UNSELECTED = 4'b1000,
        CMD_NOP        = 4'b0111,
        CMD_ACTIVE     = 4'b0011,
        CMD_READ       = 4'b0101,
        CMD_WRITE      = 4'b0100,
        CMD_PRECHARGE  = 4'b0010,
        CMD_REFRESH    = 4'b0001,
        CMD_LOAD_MODE  = 4'b0000
    } cmd_code_t;

    typedef struct packed {
        logic cs;
        logic ras;
        logic cas;
        logic we;
    } cmd_bits_t;

    // same word, decoded as a command or as individual strobes
    typedef union packed {
        cmd_code_t code;
        cmd_bits_t bits;
    } sdram_cmd_u;

    typedef struct packed {
        logic                              cke;
        sdram_cmd_u                        cmd;
        logic [sdram_geom_pkg::BANK_W-1:0] ba;
        logic [sdram_geom_pkg::ROW_W-1:0]  a;
        logic [sdram_geom_pkg::DATA_W-1:0] dq;
        logic                              dq_oe;
    } sdram_pins_t;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_PRECHARGE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_READ,
        ST_WRITE,
        ST_WAIT
    } seq_state_t;

endpackage

// File: hw/sdram_geom_pkg.sv
package sdram_geom_pkg;

    // user address and data geometry
    localparam int ADDR_W    = 23;
    localparam int ROW_W     = 13;
    localparam int BANK_W    = 2;
    localparam int COL_W     = 6;
    localparam int DATA_W    = 32;
    localparam int NUM_BANKS = 4;

    // field positions inside the user address, bits 1:0 are byte offset
    localparam int ROW_LSB  = 10;
    localparam int BANK_LSB = 8;
    localparam int COL_LSB  = 2;

    // extra wait cycles after each command, counted by the sequencer
    localparam int T_ACT_DEF            = 2;
    localparam int T_PRE_DEF            = 2;
    localparam int T_REF_DEF            = 6;
    localparam int CAS_LAT_DEF          = 3;
    localparam int REFRESH_INTERVAL_DEF = 750;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } user_req_t;

    function automatic logic [ROW_W-1:0] addr_row(input logic [ADDR_W-1:0] addr);
        return addr[ROW_LSB +: ROW_W];
    endfunction

    function automatic logic [BANK_W-1:0] addr_bank(input logic [ADDR_W-1:0] addr);
        return addr[BANK_LSB +: BANK_W];
    endfunction

    function automatic logic [COL_W-1:0] addr_col(input logic [ADDR_W-1:0] addr);
        return addr[COL_LSB +: COL_W];
    endfunction

endpackage
